// File: verilog/bp_settings.svh
`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// table geometry, index taken from next-pc bits 2 and up
`define BP_IDX_BITS  4

`define BP_ROB_BITS  5
`define BP_FL_BITS   5
`define BP_LSQ_BITS  3
`define BP_PC_BITS   64

`define BP_PHT_RESET 2'b01                 // weakly not taken
`define BP_BTB_RESET {`BP_PC_BITS{1'b0}}

// conditional branch opcodes
`define BP_OP_BLBC    6'h38
`define BP_OP_BEQ     6'h39
`define BP_OP_BLT     6'h3a
`define BP_OP_BLE     6'h3b
`define BP_OP_BLBS    6'h3c
`define BP_OP_BNE     6'h3d
`define BP_OP_BGE     6'h3e
`define BP_OP_BGT     6'h3f

// unconditional
`define BP_OP_BR      6'h30
`define BP_OP_BSR     6'h34
`define BP_OP_JSR_GRP 6'h1a

`endif

// File: verilog/bp_pkg.sv
`include "bp_settings.svh"

package bp_pkg;

  typedef logic [`BP_ROB_BITS-1:0] rob_idx_t;
  typedef logic [`BP_FL_BITS-1:0]  fl_idx_t;
  typedef logic [`BP_LSQ_BITS-1:0] lsq_idx_t;
  typedef logic [`BP_PC_BITS-1:0]  pc_t;

  typedef enum logic [1:0] {
    br_none,
    br_cond,
    br_uncond
  } br_class_t;

  // what the core needs to unwind to
  typedef struct packed {
    rob_idx_t rob_idx;
    fl_idx_t  fl_idx;
    lsq_idx_t sq_idx;
    lsq_idx_t lq_idx;
    pc_t      restart_pc;
  } rollback_info_t;

  // one resolved branch from an execution unit
  typedef struct packed {
    logic     done;
    rob_idx_t rob_idx;
    fl_idx_t  fl_idx;
    lsq_idx_t sq_idx;
    lsq_idx_t lq_idx;
    pc_t      npc;           // pc + 4 of the branch
    pc_t      predicted_pc;
    pc_t      actual_pc;
    logic     taken;
  } branch_result_t;

  typedef struct packed {
    logic     violate;
    rob_idx_t rob_idx;
    fl_idx_t  fl_idx;
    lsq_idx_t sq_idx;
    lsq_idx_t lq_idx;
    pc_t      restart_pc;
  } load_violation_t;

endpackage

// File: verilog/table_update_if.sv
`timescale 1ns/1ps
`include "bp_settings.svh"

// one training write, shared by both prediction tables
interface table_update_if;

  logic                    valid;
  logic [`BP_IDX_BITS-1:0] idx;
  logic                    taken;
  logic [`BP_PC_BITS-1:0]  target;

  modport source (output valid, idx, taken, target);
  modport sink   (input  valid, idx, taken, target);

endinterface

// File: verilog/branch_decode.sv
`timescale 1ns/1ps
`include "bp_settings.svh"

module branch_decode import bp_pkg::*; (
  input  logic                 [31:0] inst0,
  input  logic                 [31:0] inst1,
  input  logic                 [1:0]  valid,
  input  logic                        squash,
  output br_class_t            [1:0]  br_class
);

  logic [1:0][31:0] inst;

  assign inst = {inst1, inst0};

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      br_class[i] = br_none;
      if (valid[i] && !squash) begin
        case (inst[i][31:26]) // opcode field
          `BP_OP_BLBC, `BP_OP_BEQ, `BP_OP_BLT, `BP_OP_BLE,
          `BP_OP_BLBS, `BP_OP_BNE, `BP_OP_BGE, `BP_OP_BGT: begin
            br_class[i] = br_cond;
          end
          `BP_OP_BR, `BP_OP_BSR, `BP_OP_JSR_GRP: begin
            br_class[i] = br_uncond;
          end
          default: begin
            br_class[i] = br_none;
          end
        endcase
      end
    end
  end

endmodule

// File: verilog/pattern_history_table.sv
`timescale 1ns/1ps
`include "bp_settings.svh"

module pattern_history_table (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [`BP_IDX_BITS-1:0] idx0,
  input  logic [`BP_IDX_BITS-1:0] idx1,
  table_update_if.sink            upd,
  output logic [1:0]              predict_taken
);

  localparam int ENTRIES = 1 << `BP_IDX_BITS;

  logic [ENTRIES-1:0][1:0] pht;
  logic [ENTRIES-1:0][1:0] next_pht;
  logic [1:0]              cur_count;

  assign cur_count = pht[upd.idx];

  // saturating 2-bit counter step
  always_comb begin
    next_pht = pht;
    if (upd.valid) begin
      if (upd.taken && cur_count != 2'b11) begin
        next_pht[upd.idx] = cur_count + 2'd1;
      end else if (!upd.taken && cur_count != 2'b00) begin
        next_pht[upd.idx] = cur_count - 2'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pht <= {ENTRIES{`BP_PHT_RESET}};
    end else begin
      pht <= next_pht;
    end
  end

  // lookups see the pending write
  assign predict_taken[0] = next_pht[idx0][1];
  assign predict_taken[1] = next_pht[idx1][1];

  // training index comes from the arbiter, must be clean when used
  a_upd_idx_known: assert property (
    @(posedge clock) disable iff (reset)
    upd.valid |-> !$isunknown(upd.idx)
  ) else $error("pht update index unknown while valid");

endmodule

// File: verilog/target_buffer.sv
`timescale 1ns/1ps
`include "bp_settings.svh"

module target_buffer (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [`BP_IDX_BITS-1:0] idx0,
  input  logic [`BP_IDX_BITS-1:0] idx1,
  table_update_if.sink            upd,
  output logic [`BP_PC_BITS-1:0]  target0,
  output logic [`BP_PC_BITS-1:0]  target1
);

  localparam int ENTRIES = 1 << `BP_IDX_BITS;

  logic [ENTRIES-1:0][`BP_PC_BITS-1:0] btb;
  logic [ENTRIES-1:0][`BP_PC_BITS-1:0] next_btb;

  // direct mapped, last writer wins
  always_comb begin
    next_btb = btb;
    if (upd.valid) begin
      next_btb[upd.idx] = upd.target;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      btb <= {ENTRIES{`BP_BTB_RESET}};
    end else begin
      btb <= next_btb;
    end
  end

  assign target0 = next_btb[idx0];  // bypass
  assign target1 = next_btb[idx1];

endmodule

// File: verilog/oldest_select.sv
`timescale 1ns/1ps
`include "bp_settings.svh"

module oldest_select import bp_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic     valid_a,
  input  logic     valid_b,
  input  rob_idx_t age_a,
  input  rob_idx_t age_b,
  input  payload_t payload_a,
  input  payload_t payload_b,
  output logic     valid,
  output logic     pick_b,
  output rob_idx_t age,
  output payload_t payload
);

  // larger age is older and a wins a tie
  assign pick_b = valid_b && (!valid_a || (age_b > age_a));

  assign valid   = valid_a || valid_b;
  assign age     = pick_b ? age_b     : age_a;
  assign payload = pick_b ? payload_b : payload_a;

  // an invalid pick must only happen with no candidates at all
  always_comb begin
    if (!$isunknown({valid_a, valid_b, age_a, age_b})) begin
      a_valid_any: assert (valid == (pick_b ? valid_b : valid_a))
        else $error("oldest_select picked an invalid candidate");
    end
  end

endmodule

// File: verilog/recovery_arbiter.sv
`timescale 1ns/1ps
`include "bp_settings.svh"

module recovery_arbiter import bp_pkg::*; (
  input  branch_result_t  br0,
  input  branch_result_t  br1,
  input  load_violation_t ld0,
  input  load_violation_t ld1,
  input  rob_idx_t        tail_rob_idx,
  table_update_if.source  upd,
  output logic            rollback_en,
  output rollback_info_t  rollback
);

  logic [1:0]     mispredict;
  rob_idx_t       age_br0, age_br1;
  rob_idx_t       age_ld0, age_ld1;
  rob_idx_t       br_age, ld_age;
  logic           br_valid, ld_valid;
  logic           load_wins;
  branch_result_t br_win;
  rollback_info_t ld0_info, ld1_info;
  rollback_info_t br_info, ld_info;

  assign mispredict[0] = br0.done && (br0.predicted_pc != br0.actual_pc);
  assign mispredict[1] = br1.done && (br1.predicted_pc != br1.actual_pc);

  // distance from the youngest entry, wraps with the rob
  assign age_br0 = tail_rob_idx - br0.rob_idx;
  assign age_br1 = tail_rob_idx - br1.rob_idx;
  assign age_ld0 = tail_rob_idx - ld0.rob_idx;
  assign age_ld1 = tail_rob_idx - ld1.rob_idx;

  assign ld0_info = '{rob_idx: ld0.rob_idx, fl_idx: ld0.fl_idx, sq_idx: ld0.sq_idx,
                      lq_idx: ld0.lq_idx, restart_pc: ld0.restart_pc};
  assign ld1_info = '{rob_idx: ld1.rob_idx, fl_idx: ld1.fl_idx, sq_idx: ld1.sq_idx,
                      lq_idx: ld1.lq_idx, restart_pc: ld1.restart_pc};

  oldest_select #(.payload_t(branch_result_t)) u_br_select (
    .valid_a   (mispredict[0]),
    .valid_b   (mispredict[1]),
    .age_a     (age_br0),
    .age_b     (age_br1),
    .payload_a (br0),
    .payload_b (br1),
    .valid     (br_valid),
    .pick_b    (),
    .age       (br_age),
    .payload   (br_win)
  );

  oldest_select #(.payload_t(rollback_info_t)) u_ld_select (
    .valid_a   (ld0.violate),
    .valid_b   (ld1.violate),
    .age_a     (age_ld0),
    .age_b     (age_ld1),
    .payload_a (ld0_info),
    .payload_b (ld1_info),
    .valid     (ld_valid),
    .pick_b    (),
    .age       (ld_age),
    .payload   (ld_info)
  );

  // restart at the resolved target
  assign br_info = '{rob_idx: br_win.rob_idx, fl_idx: br_win.fl_idx, sq_idx: br_win.sq_idx,
                     lq_idx: br_win.lq_idx, restart_pc: br_win.actual_pc};

  // branch side is a, so it takes the tie
  oldest_select #(.payload_t(rollback_info_t)) u_final_select (
    .valid_a   (br_valid),
    .valid_b   (ld_valid),
    .age_a     (br_age),
    .age_b     (ld_age),
    .payload_a (br_info),
    .payload_b (ld_info),
    .valid     (rollback_en),
    .pick_b    (load_wins),
    .age       (),
    .payload   (rollback)
  );

  // only the winning branch trains
  assign upd.valid  = rollback_en && !load_wins;
  assign upd.idx    = br_win.npc[`BP_IDX_BITS+1:2];
  assign upd.taken  = br_win.taken;
  assign upd.target = br_win.actual_pc;

  always_comb begin
    if (!$isunknown(rollback_en)) begin
      a_rollback_has_source: assert (!rollback_en || (|mispredict) || ld0.violate || ld1.violate)
        else $error("rollback without a mispredict or load violation");
    end
  end

endmodule

// File: verilog/branch_predictor.sv
`timescale 1ns/1ps
`include "bp_settings.svh"

module branch_predictor import bp_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  pc_t         fetch_npc0,
  input  pc_t         fetch_npc1,
  input  logic [31:0] fetch_inst0,
  input  logic [31:0] fetch_inst1,
  input  logic [1:0]  fetch_valid,
  input  rob_idx_t    tail_rob_idx,
  input  logic        br0_done,
  input  rob_idx_t    br0_rob_idx,
  input  fl_idx_t     br0_fl_idx,
  input  lsq_idx_t    br0_sq_idx,
  input  lsq_idx_t    br0_lq_idx,
  input  pc_t         br0_npc,
  input  pc_t         br0_predicted_pc,
  input  pc_t         br0_actual_pc,
  input  logic        br0_taken,
  input  logic        br1_done,
  input  rob_idx_t    br1_rob_idx,
  input  fl_idx_t     br1_fl_idx,
  input  lsq_idx_t    br1_sq_idx,
  input  lsq_idx_t    br1_lq_idx,
  input  pc_t         br1_npc,
  input  pc_t         br1_predicted_pc,
  input  pc_t         br1_actual_pc,
  input  logic        br1_taken,
  input  logic        ld0_violate,
  input  rob_idx_t    ld0_rob_idx,
  input  fl_idx_t     ld0_fl_idx,
  input  lsq_idx_t    ld0_sq_idx,
  input  lsq_idx_t    ld0_lq_idx,
  input  pc_t         ld0_restart_pc,
  input  logic        ld1_violate,
  input  rob_idx_t    ld1_rob_idx,
  input  fl_idx_t     ld1_fl_idx,
  input  lsq_idx_t    ld1_sq_idx,
  input  lsq_idx_t    ld1_lq_idx,
  input  pc_t         ld1_restart_pc,
  output logic [1:0]  take_branch,
  output pc_t         redirect_pc,
  output logic [1:0]  valid_out,
  output logic        rollback_en,
  output rob_idx_t    rob_rollback_idx,
  output fl_idx_t     fl_rollback_idx,
  output lsq_idx_t    sq_rollback_idx,
  output lsq_idx_t    lq_rollback_idx
);

  branch_result_t            br0, br1;
  load_violation_t           ld0, ld1;
  rollback_info_t            rollback;
  br_class_t [1:0]           br_class;
  logic [1:0]                predict_taken;
  logic [`BP_IDX_BITS-1:0]   idx0, idx1;
  pc_t                       target0, target1;

  table_update_if upd ();

  assign br0 = '{done: br0_done, rob_idx: br0_rob_idx, fl_idx: br0_fl_idx,
                 sq_idx: br0_sq_idx, lq_idx: br0_lq_idx, npc: br0_npc,
                 predicted_pc: br0_predicted_pc, actual_pc: br0_actual_pc, taken: br0_taken};
  assign br1 = '{done: br1_done, rob_idx: br1_rob_idx, fl_idx: br1_fl_idx,
                 sq_idx: br1_sq_idx, lq_idx: br1_lq_idx, npc: br1_npc,
                 predicted_pc: br1_predicted_pc, actual_pc: br1_actual_pc, taken: br1_taken};
  assign ld0 = '{violate: ld0_violate, rob_idx: ld0_rob_idx, fl_idx: ld0_fl_idx,
                 sq_idx: ld0_sq_idx, lq_idx: ld0_lq_idx, restart_pc: ld0_restart_pc};
  assign ld1 = '{violate: ld1_violate, rob_idx: ld1_rob_idx, fl_idx: ld1_fl_idx,
                 sq_idx: ld1_sq_idx, lq_idx: ld1_lq_idx, restart_pc: ld1_restart_pc};

  assign idx0 = fetch_npc0[`BP_IDX_BITS+1:2];
  assign idx1 = fetch_npc1[`BP_IDX_BITS+1:2];

  branch_decode u_decode (
    .inst0    (fetch_inst0),
    .inst1    (fetch_inst1),
    .valid    (fetch_valid),
    .squash   (rollback_en),  // fetched slots are dead on rollback
    .br_class (br_class)
  );

  pattern_history_table u_pht (
    .clock         (clock),
    .reset         (reset),
    .idx0          (idx0),
    .idx1          (idx1),
    .upd           (upd.sink),
    .predict_taken (predict_taken)
  );

  target_buffer u_btb (
    .clock   (clock),
    .reset   (reset),
    .idx0    (idx0),
    .idx1    (idx1),
    .upd     (upd.sink),
    .target0 (target0),
    .target1 (target1)
  );

  recovery_arbiter u_arbiter (
    .br0          (br0),
    .br1          (br1),
    .ld0          (ld0),
    .ld1          (ld1),
    .tail_rob_idx (tail_rob_idx),
    .upd          (upd.source),
    .rollback_en  (rollback_en),
    .rollback     (rollback)
  );

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      take_branch[i] = (br_class[i] == br_uncond) ||
                       ((br_class[i] == br_cond) && predict_taken[i]) ||
                       rollback_en;
    end
  end

  assign valid_out[0] = fetch_valid[0] && !rollback_en;
  assign valid_out[1] = fetch_valid[1] && !rollback_en && !take_branch[0];  // behind a taken slot 0

  assign redirect_pc = rollback_en    ? rollback.restart_pc :
                       take_branch[0] ? target0 :
                       take_branch[1] ? target1 :
                       fetch_npc1;

  assign rob_rollback_idx = rollback.rob_idx;
  assign fl_rollback_idx  = rollback.fl_idx;
  assign sq_rollback_idx  = rollback.sq_idx;
  assign lq_rollback_idx  = rollback.lq_idx;

endmodule

// File: test/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// start_row(test, winner, fetch npc0, opcode0, opcode1, fetch_valid, tail rob idx)
// set_branch(slot, rob, npc, predicted, actual, taken) and set_load(slot, rob, restart)
task automatic build_table();
  start_row(1, W_NONE, 64'h1000, OP_ALU, OP_ALU, 2'b00, 5'd0);  // idle
  start_row(1, W_NONE, 64'h1000, `BP_OP_BEQ, `BP_OP_BNE, 2'b11, 5'd0);
  start_row(1, W_NONE, 64'h2038, `BP_OP_BGT, `BP_OP_BLBC, 2'b11, 5'd0);

  start_row(2, W_NONE, 64'h3010, `BP_OP_BR, `BP_OP_BEQ, 2'b11, 5'd0);
  start_row(2, W_NONE, 64'h3010, OP_ALU, `BP_OP_BSR, 2'b11, 5'd0);
  start_row(2, W_NONE, 64'h3010, `BP_OP_JSR_GRP, OP_ALU, 2'b10, 5'd0);  // slot 0 invalid

  // index 9 walks 01 -> 00 -> 01 -> 10 -> 11 -> 10
  start_row(3, W_BR0, 64'h6000, OP_ALU, OP_ALU, 2'b11, 5'd12);
  set_branch(0, 5'd4, 64'h5024, 64'h9000, 64'h5024, 1'b0);
  start_row(3, W_BR0, 64'h6000, OP_ALU, OP_ALU, 2'b11, 5'd12);
  set_branch(0, 5'd5, 64'h5024, 64'h5024, 64'h7700, 1'b1);
  start_row(3, W_NONE, 64'h5024, `BP_OP_BEQ, OP_ALU, 2'b11, 5'd12);  // one win, not yet
  start_row(3, W_BR1, 64'h6000, OP_ALU, OP_ALU, 2'b11, 5'd12);
  set_branch(1, 5'd6, 64'h5024, 64'h5024, 64'h7700, 1'b1);
  start_row(3, W_NONE, 64'h5024, `BP_OP_BNE, OP_ALU, 2'b11, 5'd12);
  start_row(3, W_NONE, 64'h5020, OP_ALU, `BP_OP_BGE, 2'b11, 5'd12);
  start_row(3, W_NONE, 64'h5024, `BP_OP_BR, OP_ALU, 2'b11, 5'd12);
  start_row(3, W_BR0, 64'h6000, OP_ALU, OP_ALU, 2'b11, 5'd12);
  set_branch(0, 5'd7, 64'h5024, 64'h5024, 64'h7700, 1'b1);
  start_row(3, W_BR0, 64'h6000, OP_ALU, OP_ALU, 2'b11, 5'd12);
  set_branch(0, 5'd8, 64'h5024, 64'h7700, 64'h5024, 1'b0);
  start_row(3, W_NONE, 64'h5024, `BP_OP_BLT, OP_ALU, 2'b11, 5'd12);  // hysteresis holds

  start_row(4, W_BR1, 64'h8000, OP_ALU, OP_ALU, 2'b11, 5'd10);
  set_branch(0, 5'd8, 64'h8104, 64'h8104, 64'h8800, 1'b1);
  set_branch(1, 5'd3, 64'h8204, 64'h8900, 64'h8204, 1'b0);
  start_row(4, W_BR0, 64'h8000, OP_ALU, OP_ALU, 2'b11, 5'd2);  // br0 sits behind the wrap
  set_branch(0, 5'd30, 64'h8304, 64'h8304, 64'h8a00, 1'b1);
  set_branch(1, 5'd1, 64'h8404, 64'h8404, 64'h8b00, 1'b1);
  start_row(4, W_BR0, 64'h8000, OP_ALU, OP_ALU, 2'b11, 5'd7);
  set_branch(0, 5'd3, 64'h8104, 64'h8104, 64'h8e00, 1'b1);
  set_branch(1, 5'd3, 64'h8404, 64'h8f00, 64'h8404, 1'b0);
  start_row(4, W_BR1, 64'h8000, OP_ALU, OP_ALU, 2'b11, 5'd7);  // older one was right
  set_branch(0, 5'd0, 64'h8104, 64'h8800, 64'h8800, 1'b1);
  set_branch(1, 5'd6, 64'h8204, 64'h8204, 64'h8c00, 1'b1);

  start_row(5, W_LD0, 64'h9000, OP_ALU, OP_ALU, 2'b11, 5'd20);
  set_branch(0, 5'd10, 64'h901c, 64'h901c, 64'ha000, 1'b1);
  set_load(0, 5'd5, 64'h9f00);
  start_row(5, W_NONE, 64'h901c, `BP_OP_BEQ, OP_ALU, 2'b11, 5'd20);  // index 7 untouched
  start_row(5, W_BR1, 64'h9000, OP_ALU, OP_ALU, 2'b11, 5'd20);
  set_branch(1, 5'd9, 64'h902c, 64'h902c, 64'ha100, 1'b1);
  set_load(1, 5'd9, 64'h9f40);
  start_row(5, W_LD1, 64'h9000, OP_ALU, OP_ALU, 2'b11, 5'd1);
  set_load(0, 5'd0, 64'h9f80);
  set_load(1, 5'd28, 64'h9fc0);
  start_row(5, W_LD0, 64'h9000, OP_ALU, OP_ALU, 2'b11, 5'd4);
  set_load(0, 5'd2, 64'haa00);
  set_load(1, 5'd2, 64'hab00);

  start_row(6, W_LD0, 64'h5024, `BP_OP_BEQ, `BP_OP_BR, 2'b11, 5'd9);
  set_load(0, 5'd3, 64'hc000);
  start_row(6, W_BR0, 64'h3010, `BP_OP_BR, OP_ALU, 2'b11, 5'd9);
  set_branch(0, 5'd8, 64'h3014, 64'h3014, 64'hd000, 1'b1);
endtask

`endif

// File: test/tb_branch_predictor.sv
`timescale 1ns/1ps
`include "bp_settings.svh"

module tb_branch_predictor import bp_pkg::*; ();

  localparam int         RESET_CYCLES = 8;
  localparam int         MARGIN       = 50;
  localparam logic [5:0] OP_ALU       = 6'h10;  // integer op, never a branch

  // which request should own the rollback
  localparam int W_NONE = 0;
  localparam int W_BR0  = 1;
  localparam int W_BR1  = 2;
  localparam int W_LD0  = 3;
  localparam int W_LD1  = 4;

  typedef struct {
    int                    test;
    int                    winner;
    pc_t                   npc0;
    logic [31:0]           inst0;
    logic [31:0]           inst1;
    logic [1:0]            fvalid;
    rob_idx_t              tail;
    branch_result_t [1:0]  br;
    load_violation_t [1:0] ld;
  } row_t;

  logic        clock, reset;
  pc_t         fetch_npc0, fetch_npc1, redirect_pc;
  logic [31:0] fetch_inst0, fetch_inst1;
  logic [1:0]  fetch_valid, take_branch, valid_out;
  rob_idx_t    tail_rob_idx, br0_rob_idx, br1_rob_idx, ld0_rob_idx, ld1_rob_idx;
  rob_idx_t    rob_rollback_idx;
  fl_idx_t     br0_fl_idx, br1_fl_idx, ld0_fl_idx, ld1_fl_idx, fl_rollback_idx;
  lsq_idx_t    br0_sq_idx, br0_lq_idx, br1_sq_idx, br1_lq_idx;
  lsq_idx_t    ld0_sq_idx, ld0_lq_idx, ld1_sq_idx, ld1_lq_idx;
  lsq_idx_t    sq_rollback_idx, lq_rollback_idx;
  pc_t         br0_npc, br0_predicted_pc, br0_actual_pc;
  pc_t         br1_npc, br1_predicted_pc, br1_actual_pc;
  pc_t         ld0_restart_pc, ld1_restart_pc;
  logic        br0_done, br0_taken, br1_done, br1_taken;
  logic        ld0_violate, ld1_violate, rollback_en;

  row_t       rows[$];
  row_t       idle_row;
  string      test_name [1:6];
  logic [1:0] model_pht [16];  // reference counters
  pc_t        model_btb [16];
  int         errors      = 0;
  int         checks      = 0;
  int         test_errors = 0;
  int         tests_done  = 0;
  int         cycle_count = 0;
  int         cycle_limit = RESET_CYCLES + MARGIN;

  branch_predictor u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: vector table did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [255:0] fill_noise();
    logic [255:0] noise;
    for (int w = 0; w < 8; w++) begin
      noise[w*32 +: 32] = $urandom;
    end
    return noise;
  endfunction

  // opcode groups as the ISA defines them
  function automatic br_class_t classify_op(input logic [5:0] op);
    if (op >= 6'h38) return br_cond;
    if (op == `BP_OP_BR || op == `BP_OP_BSR || op == `BP_OP_JSR_GRP) return br_uncond;
    return br_none;
  endfunction

  task automatic start_row(input int test, input int winner, input pc_t npc0,
                           input logic [5:0] op0, input logic [5:0] op1,
                           input logic [1:0] fvalid, input rob_idx_t tail);
    row_t         r;
    logic [255:0] noise;
    r.test   = test;
    r.winner = winner;
    r.npc0   = npc0;
    r.inst0  = {op0, 26'($urandom)};
    r.inst1  = {op1, 26'($urandom)};
    r.fvalid = fvalid;
    r.tail   = tail;
    for (int s = 0; s < 2; s++) begin
      noise = fill_noise();
      r.br[s] = noise[$bits(branch_result_t)-1:0];  // idle filler
      r.br[s].done = 1'b0;
      noise = fill_noise();
      r.ld[s] = noise[$bits(load_violation_t)-1:0];
      r.ld[s].violate = 1'b0;
    end
    rows.push_back(r);
  endtask

  task automatic set_branch(input int slot, input rob_idx_t rob, input pc_t npc,
                            input pc_t pred, input pc_t actual, input logic taken);
    row_t r;
    r = rows[rows.size()-1];
    r.br[slot].done         = 1'b1;
    r.br[slot].rob_idx      = rob;
    r.br[slot].npc          = npc;
    r.br[slot].predicted_pc = pred;
    r.br[slot].actual_pc    = actual;
    r.br[slot].taken        = taken;
    rows[rows.size()-1] = r;
  endtask

  task automatic set_load(input int slot, input rob_idx_t rob, input pc_t restart);
    row_t r;
    r = rows[rows.size()-1];
    r.ld[slot].violate    = 1'b1;
    r.ld[slot].rob_idx    = rob;
    r.ld[slot].restart_pc = restart;
    rows[rows.size()-1] = r;
  endtask

  `include "tb_vectors.svh"

  task automatic drive_row(input row_t r);
    fetch_npc0   = r.npc0;
    fetch_npc1   = r.npc0 + 64'd4;
    fetch_inst0  = r.inst0;
    fetch_inst1  = r.inst1;
    fetch_valid  = r.fvalid;
    tail_rob_idx = r.tail;
    {br0_done, br0_rob_idx, br0_fl_idx, br0_sq_idx, br0_lq_idx, br0_npc,
     br0_predicted_pc, br0_actual_pc, br0_taken} = r.br[0];
    {br1_done, br1_rob_idx, br1_fl_idx, br1_sq_idx, br1_lq_idx, br1_npc,
     br1_predicted_pc, br1_actual_pc, br1_taken} = r.br[1];
    {ld0_violate, ld0_rob_idx, ld0_fl_idx, ld0_sq_idx, ld0_lq_idx, ld0_restart_pc} = r.ld[0];
    {ld1_violate, ld1_rob_idx, ld1_fl_idx, ld1_sq_idx, ld1_lq_idx, ld1_restart_pc} = r.ld[1];
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_row(input row_t r);
    branch_result_t  wb;
    load_violation_t wl;
    rollback_info_t  exp_rb;
    logic            exp_en;
    logic [1:0]      exp_take, exp_valid;
    pc_t             exp_redirect, npc1;
    logic [1:0]      pht_next [16];
    pc_t             btb_next [16];
    logic [3:0]      fidx [2];
    logic [3:0]      uidx;
    br_class_t       cls;
    wb = (r.winner == W_BR1) ? r.br[1] : r.br[0];
    wl = (r.winner == W_LD1) ? r.ld[1] : r.ld[0];
    exp_en = (r.winner != W_NONE);
    if (r.winner == W_LD0 || r.winner == W_LD1) begin
      exp_rb = '{wl.rob_idx, wl.fl_idx, wl.sq_idx, wl.lq_idx, wl.restart_pc};
    end else begin
      exp_rb = '{wb.rob_idx, wb.fl_idx, wb.sq_idx, wb.lq_idx, wb.actual_pc};
    end
    // winning branch trains, lookups see it at once
    pht_next = model_pht;
    btb_next = model_btb;
    if (r.winner == W_BR0 || r.winner == W_BR1) begin
      uidx = wb.npc[`BP_IDX_BITS+1:2];
      if (wb.taken && pht_next[uidx] != 2'b11) begin
        pht_next[uidx] = pht_next[uidx] + 2'd1;
      end else if (!wb.taken && pht_next[uidx] != 2'b00) begin
        pht_next[uidx] = pht_next[uidx] - 2'd1;
      end
      btb_next[uidx] = wb.actual_pc;
    end
    npc1    = r.npc0 + 64'd4;
    fidx[0] = r.npc0[`BP_IDX_BITS+1:2];
    fidx[1] = npc1[`BP_IDX_BITS+1:2];
    for (int s = 0; s < 2; s++) begin
      cls = classify_op(s == 0 ? r.inst0[31:26] : r.inst1[31:26]);
      exp_take[s] = exp_en || (r.fvalid[s] && (cls == br_uncond ||
                    (cls == br_cond && pht_next[fidx[s]][1])));
    end
    exp_valid[0] = r.fvalid[0] && !exp_en;
    exp_valid[1] = r.fvalid[1] && !exp_en && !exp_take[0];
    exp_redirect = exp_en ? exp_rb.restart_pc : exp_take[0] ? btb_next[fidx[0]] :
                   exp_take[1] ? btb_next[fidx[1]] : npc1;
    check_value("take_branch", 64'(exp_take), 64'(take_branch));
    check_value("valid_out", 64'(exp_valid), 64'(valid_out));
    check_value("redirect_pc", exp_redirect, redirect_pc);
    check_value("rollback_en", 64'(exp_en), 64'(rollback_en));
    if (exp_en) begin
      check_value("rob_rollback_idx", 64'(exp_rb.rob_idx), 64'(rob_rollback_idx));
      check_value("fl_rollback_idx", 64'(exp_rb.fl_idx), 64'(fl_rollback_idx));
      check_value("sq_rollback_idx", 64'(exp_rb.sq_idx), 64'(sq_rollback_idx));
      check_value("lq_rollback_idx", 64'(exp_rb.lq_idx), 64'(lq_rollback_idx));
    end
    model_pht = pht_next;  // tables update on the coming edge
    model_btb = btb_next;
  endtask

  task automatic report_test(input int test);
    tests_done++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", test, test_name[test]);
    end else begin
      $display("test %0d %s: %0d errors", test, test_name[test], test_errors);
    end
    test_errors = 0;
  endtask

  initial begin
    int cur_test;
    void'($urandom(32'h1d2));
    reset = 1'b1;
    idle_row = '{test: 0, winner: W_NONE, npc0: '0, inst0: '0, inst1: '0,
                 fvalid: '0, tail: '0, br: '0, ld: '0};
    drive_row(idle_row);
    test_name[1] = "reset state";
    test_name[2] = "decode and slot squash";
    test_name[3] = "training";
    test_name[4] = "branch age";
    test_name[5] = "load against branch";
    test_name[6] = "rollback overrides fetch";
    for (int i = 0; i < 16; i++) begin
      model_pht[i] = `BP_PHT_RESET;
      model_btb[i] = `BP_BTB_RESET;
    end
    build_table();
    cycle_limit = rows.size() + RESET_CYCLES + MARGIN;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset = 1'b0;
    cur_test = rows[0].test;
    foreach (rows[n]) begin
      if (rows[n].test != cur_test) begin
        report_test(cur_test);
        cur_test = rows[n].test;
      end
      @(posedge clock);
      #1 drive_row(rows[n]);
      #5 check_row(rows[n]);
    end
    report_test(cur_test);
    $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: branch_predictor.f
+incdir+verilog
+incdir+test
verilog/bp_pkg.sv
verilog/table_update_if.sv
verilog/branch_decode.sv
verilog/pattern_history_table.sv
verilog/target_buffer.sv
verilog/oldest_select.sv
verilog/recovery_arbiter.sv
verilog/branch_predictor.sv
test/tb_branch_predictor.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= branch_predictor.f
RTL_TOP   ?= branch_predictor
TB_TOP    ?= tb_branch_predictor
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --timing --assert

SOURCES := $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh test/*.sv test/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
	  --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@grep -q "TB PASSED" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
